// ==== static_slave.f ====
src/cnfg_pkg.sv
src/queue_stream.sv
src/axil_reg_port.sv
src/cnfg_regfile.sv
src/static_slave.sv
tb/tb_clock.sv
tb/static_slave_assertions.sv
tb/static_slave_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the static_slave testbench with Verilator, run it and check the log

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module static_slave_tb -f static_slave.f -o sim_static_slave \
  && ./obj_dir/sim_static_slave > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^ALL TESTS PASSED$" sim.log 2>/dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// ==== tb/static_slave_tb.sv ====
// Static slave testbench
// Random register traffic over AXI4-Lite with back-pressure, checked against
// a register model. A DMA sink takes PR descriptors and answers with done.

`timescale 1ns/1ps

module static_slave_tb import cnfg_pkg::*; ();

  localparam int unsigned RAND_SEED = 32'hf89d;
  localparam int N_RW      = 40;
  localparam int N_STARTS  = 12;
  localparam int N_MIX     = 30;
  localparam int TXN_COUNT = 16 + 2 * N_RW + 30 + 3 * (N_STARTS + PR_QUEUE_DEPTH + 1)
                             + 6 + N_MIX;

  logic      aclk;
  logic      aresetn;
  axil_req_t axi_req;
  axil_rsp_t axi_rsp;
  logic [2:0] lowspeed_ctrl;
  logic      dma_valid;
  logic      dma_ready;
  dma_req_t  dma_req;
  logic      dma_done;

  // Register model
  logic [63:0] m_probe;
  logic [63:0] m_addr;
  logic [31:0] m_len;
  logic [2:0]  m_ls;
  logic        m_done;
  dma_req_t    exp_q[$];   // Descriptors inside the DUT queue

  int n_checks;
  int n_errors;
  int n_writes;
  int n_reads;
  int b_seen;
  int r_seen;
  int done_owed;
  int done_wait;
  bit sink_hold;
  int rw_regs[4] = '{PROBE_REG, PR_ADDR_REG, PR_LEN_REG, LOWSPEED_REG};

  tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(10)) u_clk (.aclk(aclk), .aresetn(aresetn));

  static_slave dut (
    .aclk, .aresetn, .axi_req, .axi_rsp, .lowspeed_ctrl,
    .dma_valid, .dma_ready, .dma_req, .dma_done
  );

  bind static_slave static_slave_assertions u_sva (
    .aclk(aclk), .aresetn(aresetn), .axi_req(axi_req), .axi_rsp(axi_rsp),
    .dma_valid(dma_valid), .dma_ready(dma_ready), .dma_req(dma_req)
  );

  // --------------------------------------------------------------------------
  // Checking and model
  // --------------------------------------------------------------------------
  task automatic compare_values(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [63:0] apply_strobes(input logic [63:0] cur,
                                                input logic [63:0] wdat,
                                                input logic [7:0] be);
    logic [63:0] mask;
    for (int b = 0; b < 8; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return (cur & ~mask) | (wdat & mask);
  endfunction

  function automatic void model_write(input int idx, input logic [63:0] wdat,
                                      input logic [7:0] be);
    logic [63:0] len_full;
    len_full = apply_strobes({32'b0, m_len}, wdat, be);
    case (idx)
      PROBE_REG:    m_probe = apply_strobes(m_probe, wdat, be);
      PR_ADDR_REG:  m_addr = apply_strobes(m_addr, wdat, be);
      PR_LEN_REG:   m_len = len_full[31:0];
      LOWSPEED_REG: if (be[0]) m_ls = wdat[2:0];
      default: ;   // Read-only, PR control or unmapped
    endcase
  endfunction

  function automatic logic [63:0] expected_read(input int idx);
    logic q_room;
    q_room = (exp_q.size() < PR_QUEUE_DEPTH);
    case (idx)
      PROBE_REG:     return m_probe;
      N_CHAN_REG:    return 64'(N_CHAN);
      N_REGIONS_REG: return 64'(N_REGIONS);
      CTRL_CNFG_REG: return {62'b0, BPSS_FLOW, AVX_FLOW};
      MEM_CNFG_REG:  return {58'b0, N_DDR_CHAN, DDR_FLOW};
      PR_CNFG_REG:   return {63'b0, PR_FLOW};
      LOWSPEED_REG:  return {61'b0, m_ls};
      PR_STAT_REG:   return {62'b0, q_room, m_done};
      PR_ADDR_REG:   return m_addr;
      PR_LEN_REG:    return {32'b0, m_len};
      default:       return 64'b0;   // PR_CTRL self-clears, rest unmapped
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Bus tasks
  // --------------------------------------------------------------------------
  task automatic bus_write(input int idx, input logic [63:0] wdat, input logic [7:0] be);
    bit taken;
    @(posedge aclk);
    axi_req.awaddr  <= AXIL_ADDR_BITS'(idx << ADDR_LSB);
    axi_req.awvalid <= 1'b1;
    axi_req.wdata   <= wdat;
    axi_req.wstrb   <= be;
    axi_req.wvalid  <= 1'b1;
    do @(posedge aclk); while (!axi_rsp.awready);
    compare_values(64'(axi_rsp.wready), 64'h1, "wready with awready");
    axi_req.awvalid <= 1'b0;
    axi_req.wvalid  <= 1'b0;
    axi_req.bready  <= ($urandom_range(0, 2) == 0);
    do begin
      @(posedge aclk);
      taken = axi_rsp.bvalid && axi_req.bready;
      if (!taken) axi_req.bready <= ($urandom_range(0, 2) == 0);   // Back-pressure
    end while (!taken);
    compare_values(64'(axi_rsp.bresp), 64'h0, "bresp");
    axi_req.bready <= 1'b0;
    n_writes++;
  endtask

  task automatic bus_read(input int idx, output logic [63:0] rdat);
    bit taken;
    @(posedge aclk);
    axi_req.araddr  <= AXIL_ADDR_BITS'(idx << ADDR_LSB);
    axi_req.arvalid <= 1'b1;
    do @(posedge aclk); while (!axi_rsp.arready);
    axi_req.arvalid <= 1'b0;
    axi_req.rready  <= ($urandom_range(0, 2) == 0);
    do begin
      @(posedge aclk);
      taken = axi_rsp.rvalid && axi_req.rready;
      rdat  = axi_rsp.rdata;
      if (!taken) axi_req.rready <= ($urandom_range(0, 2) == 0);
    end while (!taken);
    compare_values(64'(axi_rsp.rresp), 64'h0, "rresp");
    axi_req.rready <= 1'b0;
    n_reads++;
  endtask

  // Random address, length and ctl, then the start bit
  task automatic issue_start(input bit queued);
    logic [63:0] addr;
    logic [63:0] len_word;
    dma_req_t    d;
    addr     = {$urandom, $urandom};
    len_word = {$urandom, $urandom};
    d.ctl    = 1'($urandom_range(0, 1));
    bus_write(PR_ADDR_REG, addr, 8'hff);
    model_write(PR_ADDR_REG, addr, 8'hff);
    bus_write(PR_LEN_REG, len_word, 8'hff);
    model_write(PR_LEN_REG, len_word, 8'hff);
    d.paddr = m_addr;
    d.len   = m_len;
    if (queued) begin
      while (exp_q.size() >= PR_QUEUE_DEPTH) @(posedge aclk);
      exp_q.push_back(d);
    end
    bus_write(PR_CTRL_REG, {62'b0, d.ctl, 1'b1}, 8'h01);
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (n_errors == errs_before) $display("Test %0d %s: passed", num, name);
    else $display("Test %0d %s: failed with %0d errors", num, name, n_errors - errs_before);
  endtask

  // --------------------------------------------------------------------------
  // DMA sink and response monitor
  // --------------------------------------------------------------------------
  initial begin : dma_sink
    dma_req_t d;
    dma_ready = 1'b0;
    dma_done  = 1'b0;
    forever begin
      @(posedge aclk);
      if (aresetn === 1'b1) begin
        if (dma_valid && dma_ready) begin
          if (exp_q.size() == 0) begin
            n_errors++;
            $display("DMA sink got a descriptor that was not expected at %0t", $time);
          end else begin
            d = exp_q.pop_front();
            compare_values(64'(dma_req.ctl), 64'(d.ctl), "descriptor ctl");
            compare_values(dma_req.paddr, d.paddr, "descriptor paddr");
            compare_values(64'(dma_req.len), 64'(d.len), "descriptor len");
          end
          done_owed++;
        end
        dma_ready <= sink_hold ? 1'b0 : 1'($urandom_range(0, 1));
        dma_done  <= 1'b0;
        if (done_wait > 0) begin
          done_wait--;
        end else if (done_owed > 0) begin
          dma_done  <= 1'b1;   // One-cycle pulse
          done_owed--;
          m_done    = 1'b1;
          done_wait = $urandom_range(1, 6);
        end
      end
    end
  end

  // Each response counted once, when its valid rises
  initial begin : resp_monitor
    logic b_prev;
    logic r_prev;
    b_prev = 1'b0;
    r_prev = 1'b0;
    forever begin
      @(posedge aclk);
      if (axi_rsp.bvalid === 1'b1 && !b_prev) b_seen++;
      if (axi_rsp.rvalid === 1'b1 && !r_prev) r_seen++;
      b_prev = (axi_rsp.bvalid === 1'b1);
      r_prev = (axi_rsp.rvalid === 1'b1);
    end
  end

  initial begin : watchdog
    repeat (20 + 200 * TXN_COUNT) @(posedge aclk);
    $display("Watchdog: the run timed out before all tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin : main
    logic [63:0] rdat;
    logic [63:0] wdat;
    logic [7:0]  be;
    int          idx;
    int          mark;
    void'($urandom(RAND_SEED));
    axi_req  = '0;
    m_probe  = '0;
    m_addr   = '0;
    m_len    = '0;
    m_ls     = 3'b111;
    m_done   = 1'b0;
    wait (aresetn === 1'b1);
    repeat (2) @(posedge aclk);

    mark = n_errors;   // 1: reset values and constants
    compare_values(64'(lowspeed_ctrl), 64'h7, "lowspeed_ctrl after reset");
    for (int i = 0; i < 16; i++) begin
      bus_read(i, rdat);
      compare_values(rdat, expected_read(i), $sformatf("reset read of reg %0d", i));
    end
    report_test(1, "reset values", mark);

    mark = n_errors;   // 2: strobed writes and readback
    for (int i = 0; i < N_RW; i++) begin
      idx  = rw_regs[$urandom_range(0, 3)];
      wdat = {$urandom, $urandom};
      be   = 8'($urandom);
      bus_write(idx, wdat, be);
      model_write(idx, wdat, be);
      if (idx == LOWSPEED_REG) compare_values(64'(lowspeed_ctrl), 64'(m_ls), "lowspeed_ctrl");
      idx = rw_regs[$urandom_range(0, 3)];
      bus_read(idx, rdat);
      compare_values(rdat, expected_read(idx), $sformatf("readback of reg %0d", idx));
    end
    report_test(2, "strobed writes", mark);

    mark = n_errors;   // 3: read-only and PR_CTRL writes
    for (int i = 1; i < 16; i++) begin
      if (i inside {PROBE_REG, LOWSPEED_REG, PR_CTRL_REG, PR_ADDR_REG, PR_LEN_REG}) continue;
      bus_write(i, {$urandom, $urandom}, 8'hff);
    end
    bus_write(PR_CTRL_REG, {$urandom, $urandom} & ~64'h7, 8'hff);   // No start, no clear
    for (int i = 0; i < 16; i++) begin
      bus_read(i, rdat);
      compare_values(rdat, expected_read(i), $sformatf("read-only check of reg %0d", i));
    end
    report_test(3, "read-only writes", mark);

    mark = n_errors;   // 4: PR descriptors in order, drop while full
    for (int i = 0; i < N_STARTS; i++) issue_start(1'b1);
    while (exp_q.size() != 0) @(posedge aclk);
    sink_hold = 1'b1;
    repeat (2) @(posedge aclk);
    for (int i = 0; i < PR_QUEUE_DEPTH; i++) issue_start(1'b1);
    bus_read(PR_STAT_REG, rdat);
    compare_values(64'(rdat[PR_READY]), 64'h0, "PR_STAT ready with queue full");
    issue_start(1'b0);                      // Must be dropped
    repeat (4) @(posedge aclk);
    sink_hold = 1'b0;
    while (exp_q.size() != 0) @(posedge aclk);
    repeat (20) @(posedge aclk);            // Room for a stray descriptor to show up
    bus_read(PR_STAT_REG, rdat);
    compare_values(64'(rdat[PR_READY]), 64'h1, "PR_STAT ready after drain");
    report_test(4, "PR descriptors", mark);

    mark = n_errors;   // 5: sticky done and clear
    while (done_owed != 0 || done_wait != 0) @(posedge aclk);
    repeat (3) @(posedge aclk);
    bus_read(PR_STAT_REG, rdat);
    compare_values(rdat, expected_read(PR_STAT_REG), "PR_STAT after done");
    compare_values(64'(rdat[PR_DONE]), 64'h1, "done bit set");
    repeat ($urandom_range(1, 20)) @(posedge aclk);
    bus_read(PR_STAT_REG, rdat);
    compare_values(64'(rdat[PR_DONE]), 64'h1, "done bit still set");
    bus_write(PR_CTRL_REG, 64'h1 << PR_CLR, 8'h01);
    m_done = 1'b0;
    bus_read(PR_STAT_REG, rdat);
    compare_values(rdat, expected_read(PR_STAT_REG), "PR_STAT after clear");
    report_test(5, "sticky done", mark);

    mark = n_errors;   // 6: mixed traffic, one response per transaction
    for (int i = 0; i < N_MIX; i++) begin
      idx = rw_regs[$urandom_range(0, 3)];
      if ($urandom_range(0, 1) == 1) begin
        wdat = {$urandom, $urandom};
        be   = 8'($urandom);
        bus_write(idx, wdat, be);
        model_write(idx, wdat, be);
      end else begin
        bus_read(idx, rdat);
        compare_values(rdat, expected_read(idx), $sformatf("mixed read of reg %0d", idx));
      end
    end
    repeat (5) @(posedge aclk);
    compare_values(64'(b_seen), 64'(n_writes), "write response count");
    compare_values(64'(r_seen), 64'(n_reads), "read response count");
    report_test(6, "back-pressure", mark);

    $display("Checks: %0d, errors: %0d, writes: %0d, reads: %0d",
             n_checks, n_errors, n_writes, n_reads);
    if (n_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/static_slave_assertions.sv ====
// Handshake assertions for the static slave
// Valids hold until taken, the DMA descriptor holds while stalled and
// the write channel never has two responses in flight

`timescale 1ns/1ps

module static_slave_assertions import cnfg_pkg::*; (
  input logic      aclk,
  input logic      aresetn,
  input axil_req_t axi_req,
  input axil_rsp_t axi_rsp,
  input logic      dma_valid,
  input logic      dma_ready,
  input dma_req_t  dma_req
);

  // --------------------------------------------------------------------------
  // Valid stays high until the handshake
  // --------------------------------------------------------------------------
  aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axi_req.awvalid && !axi_rsp.awready |=> axi_req.awvalid)
    else $error("awvalid dropped before awready");
  w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axi_req.wvalid && !axi_rsp.wready |=> axi_req.wvalid)
    else $error("wvalid dropped before wready");
  ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axi_req.arvalid && !axi_rsp.arready |=> axi_req.arvalid)
    else $error("arvalid dropped before arready");
  b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axi_rsp.bvalid && !axi_req.bready |=> axi_rsp.bvalid)
    else $error("bvalid dropped before bready");
  r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axi_rsp.rvalid && !axi_req.rready |=> axi_rsp.rvalid)
    else $error("rvalid dropped before rready");
  dma_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    dma_valid && !dma_ready |=> dma_valid)
    else $error("dma_valid dropped before dma_ready");

  // Stalled descriptor must not change
  dma_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    dma_valid && !dma_ready |=> $stable(dma_req))
    else $error("dma_req changed while stalled");

  // New write accepted only once the last response is gone
  one_bresp: assert property (@(posedge aclk) disable iff (!aresetn)
    !(axi_rsp.awready && axi_rsp.bvalid))
    else $error("write accepted with a response outstanding");

endmodule

// ==== tb/tb_clock.sv ====
// Testbench clock and reset
// Free-running clock and an active-low reset held for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    aresetn <= 1'b1;   // Released on a clock edge
  end

endmodule

// ==== src/static_slave.sv ====
// Static configuration slave
// Host-facing register block of the shell. AXI4-Lite port in front of the
// register file, with PR descriptors queued toward the H2C DMA engine.

`timescale 1ns/1ps

module static_slave import cnfg_pkg::*; (
  input  logic      aclk,
  input  logic      aresetn,
  input  axil_req_t axi_req,      // Host control bus
  output axil_rsp_t axi_rsp,
  output logic [2:0] lowspeed_ctrl,
  output logic      dma_valid,    // PR descriptors
  input  logic      dma_ready,
  output dma_req_t  dma_req,
  input  logic      dma_done
);

  logic                      wr_en;
  reg_wr_t                   wr;
  logic                      rd_en;
  logic [ADDR_MSB-1:0]       rd_idx;
  logic [AXIL_DATA_BITS-1:0] rd_data;
  logic                      q_valid;
  logic                      q_ready;
  dma_req_t                  q_req;

  axil_reg_port u_port (
    .aclk, .aresetn, .axi_req, .axi_rsp,
    .wr_en, .wr, .rd_en, .rd_idx, .rd_data
  );

  cnfg_regfile u_regs (
    .aclk, .aresetn, .wr_en, .wr, .rd_en, .rd_idx, .rd_data,
    .lowspeed_ctrl, .q_valid, .q_req, .q_ready, .dma_done
  );

  // Descriptor queue toward the DMA engine
  queue_stream #(
    .QTYPE  (dma_req_t),
    .QDEPTH (PR_QUEUE_DEPTH)
  ) u_pr_queue (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .val_snk  (q_valid),
    .rdy_snk  (q_ready),
    .data_snk (q_req),
    .val_src  (dma_valid),
    .rdy_src  (dma_ready),
    .data_src (dma_req)
  );

endmodule

// ==== src/cnfg_regfile.sv ====
// Configuration register file
// Holds the writable registers, returns build constants on read and runs
// the PR control path. A start write offers one DMA descriptor to the
// queue and a done pulse from the DMA engine sets a sticky status bit.

`timescale 1ns/1ps

module cnfg_regfile import cnfg_pkg::*; (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      wr_en,
  input  reg_wr_t                   wr,
  input  logic                      rd_en,
  input  logic [ADDR_MSB-1:0]       rd_idx,
  output logic [AXIL_DATA_BITS-1:0] rd_data,
  output logic [2:0]                lowspeed_ctrl,
  output logic                      q_valid,
  output dma_req_t                  q_req,
  input  logic                      q_ready,
  input  logic                      dma_done
);

  logic [AXIL_DATA_BITS-1:0] probe;
  logic [AXIL_DATA_BITS-1:0] pr_addr;
  logic [31:0]               pr_len;
  logic [15:0]               pr_ctrl;
  logic [2:0]                lowspeed;
  logic                      done;
  logic [AXIL_DATA_BITS-1:0] ctrl_merged;
  logic [AXIL_DATA_BITS-1:0] len_merged;
  logic [AXIL_DATA_BITS-1:0] rd_mux;

  // Byte-enable merge of new data into an old value
  function automatic logic [AXIL_DATA_BITS-1:0] byte_merge(
    input logic [AXIL_DATA_BITS-1:0]   old_val,
    input logic [AXIL_DATA_BITS-1:0]   new_val,
    input logic [AXIL_DATA_BITS/8-1:0] strb
  );
    logic [AXIL_DATA_BITS-1:0] res;
    res = old_val;
    for (int i = 0; i < AXIL_DATA_BITS / 8; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // PR_CTRL starts from zero each write, PR_LEN keeps its low word only
  assign ctrl_merged = byte_merge('0, wr.data, wr.strb & 8'h03);
  assign len_merged  = byte_merge({32'b0, pr_len}, wr.data, wr.strb & 8'h0f);

  // --------------------------------------------------------------------------
  // Register storage
  // --------------------------------------------------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      probe    <= '0;
      pr_addr  <= '0;
      pr_len   <= '0;
      pr_ctrl  <= '0;
      lowspeed <= 3'b111;   // Pins idle high
      done     <= 1'b0;
    end else begin
      pr_ctrl <= '0;        // Self-clearing after one cycle
      if (pr_ctrl[PR_CLR]) begin
        done <= 1'b0;       // Clear beats a same-cycle done
      end else if (dma_done) begin
        done <= 1'b1;
      end

      if (wr_en) begin
        case (wr.idx)
          PROBE_REG:    probe   <= byte_merge(probe, wr.data, wr.strb);
          PR_ADDR_REG:  pr_addr <= byte_merge(pr_addr, wr.data, wr.strb);
          PR_LEN_REG:   pr_len  <= len_merged[31:0];
          PR_CTRL_REG:  pr_ctrl <= ctrl_merged[15:0];
          LOWSPEED_REG: begin
            if (wr.strb[0]) begin
              lowspeed <= wr.data[2:0];
            end
          end
          default: ;        // Read-only or unmapped
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    case (rd_idx)
      PROBE_REG:     rd_mux = probe;
      N_CHAN_REG:    rd_mux = AXIL_DATA_BITS'(N_CHAN);
      N_REGIONS_REG: rd_mux = AXIL_DATA_BITS'(N_REGIONS);
      CTRL_CNFG_REG: rd_mux[1:0] = {BPSS_FLOW, AVX_FLOW};
      MEM_CNFG_REG:  rd_mux[5:0] = {N_DDR_CHAN, DDR_FLOW};
      PR_CNFG_REG:   rd_mux[0] = PR_FLOW;
      LOWSPEED_REG:  rd_mux[2:0] = lowspeed;
      PR_STAT_REG: begin
        rd_mux[PR_READY] = q_ready;
        rd_mux[PR_DONE]  = done;
      end
      PR_ADDR_REG:   rd_mux = pr_addr;
      PR_LEN_REG:    rd_mux[31:0] = pr_len;
      default: ;
    endcase
  end

  // Held until the next read so rdata stays put under back-pressure
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= rd_mux;
    end
  end

  assign lowspeed_ctrl = lowspeed;

  // Descriptor offered for the single cycle the start bit is set
  assign q_valid     = pr_ctrl[PR_START];
  assign q_req.ctl   = pr_ctrl[PR_CTL];
  assign q_req.paddr = pr_addr;
  assign q_req.len   = pr_len;

endmodule

// ==== src/axil_reg_port.sv ====
// AXI4-Lite register port
// Accepts host writes and reads one at a time and hands them to the
// register file as single-cycle strobes. Write address and data must
// arrive together. Responses are always OKAY.

`timescale 1ns/1ps

module axil_reg_port import cnfg_pkg::*; (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  axil_req_t                 axi_req,
  output axil_rsp_t                 axi_rsp,
  output logic                      wr_en,
  output reg_wr_t                   wr,
  output logic                      rd_en,
  output logic [ADDR_MSB-1:0]       rd_idx,
  input  logic [AXIL_DATA_BITS-1:0] rd_data
);

  logic                aw_en;      // Low while a write response is outstanding
  logic                wr_ready;   // Drives both awready and wready
  logic                b_valid;
  logic                ar_ready;
  logic                r_valid;
  logic [ADDR_MSB-1:0] ar_idx;
  logic                wr_accept;
  logic                ar_accept;

  // --------------------------------------------------------------------------
  // Write channel
  // --------------------------------------------------------------------------
  assign wr_accept = ~wr_ready && axi_req.awvalid && axi_req.wvalid && aw_en;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ready <= 1'b0;
      aw_en    <= 1'b1;
    end else begin
      wr_ready <= wr_accept;  // One-cycle pulse
      if (wr_accept) begin
        aw_en <= 1'b0;
      end else if (axi_req.bready && b_valid) begin
        aw_en <= 1'b1;
      end
    end
  end

  // Write address and payload, captured on accept
  always_ff @(posedge aclk) begin
    if (wr_accept) begin
      wr.idx  <= axi_req.awaddr[ADDR_LSB +: ADDR_MSB];
      wr.data <= axi_req.wdata;
      wr.strb <= axi_req.wstrb;
    end
  end

  // Strobe to the register file while both channels handshake
  assign wr_en = wr_ready && axi_req.awvalid && axi_req.wvalid;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      b_valid <= 1'b0;
    end else if (wr_en) begin
      b_valid <= 1'b1;
    end else if (axi_req.bready) begin
      b_valid <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Read channel
  // --------------------------------------------------------------------------
  // No new read while the previous data still waits for rready
  assign ar_accept = ~ar_ready && axi_req.arvalid && ~r_valid;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ar_ready <= 1'b0;
    end else begin
      ar_ready <= ar_accept;
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_accept) begin
      ar_idx <= axi_req.araddr[ADDR_LSB +: ADDR_MSB];
    end
  end

  assign rd_en  = ar_ready && axi_req.arvalid;
  assign rd_idx = ar_idx;

  // Data comes back registered, so rvalid follows rd_en by one edge
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      r_valid <= 1'b0;
    end else if (rd_en) begin
      r_valid <= 1'b1;
    end else if (axi_req.rready) begin
      r_valid <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Response bundle
  // --------------------------------------------------------------------------
  assign axi_rsp.awready = wr_ready;
  assign axi_rsp.wready  = wr_ready;
  assign axi_rsp.bresp   = 2'b00;    // OKAY
  assign axi_rsp.bvalid  = b_valid;
  assign axi_rsp.arready = ar_ready;
  assign axi_rsp.rdata   = rd_data;
  assign axi_rsp.rresp   = 2'b00;
  assign axi_rsp.rvalid  = r_valid;

endmodule

// ==== src/queue_stream.sv ====
// Valid/ready stream FIFO
// Circular buffer with an occupancy count and a payload of any type.
// The sink side is ready while the buffer has room.

`timescale 1ns/1ps

module queue_stream #(
  parameter type QTYPE  = logic [31:0],
  parameter int  QDEPTH = 4
) (
  input  logic aclk,
  input  logic aresetn,
  input  logic val_snk,
  output logic rdy_snk,
  input  QTYPE data_snk,
  output logic val_src,
  input  logic rdy_src,
  output QTYPE data_src
);

  QTYPE                        mem [QDEPTH];
  logic [$clog2(QDEPTH)-1:0]   wr_ptr;
  logic [$clog2(QDEPTH)-1:0]   rd_ptr;
  logic [$clog2(QDEPTH+1)-1:0] count;
  logic                        push;
  logic                        pop;

  assign rdy_snk  = (count != QDEPTH);
  assign val_src  = (count != 0);
  assign data_src = mem[rd_ptr];   // Head entry
  assign push     = val_snk && rdy_snk;
  assign pop      = val_src && rdy_src;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == QDEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == QDEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;   // Both or neither
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= data_snk;
    end
  end

endmodule

// ==== src/cnfg_pkg.sv ====
// Static configuration package
// Host bus widths, register map indices, build constants and the packed
// structs shared by the AXI4-Lite port, the register file and the PR queue

package cnfg_pkg;

  // ------------------------------------------------------------------------
  // Bus and map sizes
  // ------------------------------------------------------------------------
  localparam int AXIL_DATA_BITS = 64;
  localparam int N_REGS         = 14;
  localparam int ADDR_LSB       = $clog2(AXIL_DATA_BITS / 8);  // Byte offset
  localparam int ADDR_MSB       = $clog2(N_REGS);              // Register index
  localparam int AXIL_ADDR_BITS = ADDR_LSB + ADDR_MSB;
  localparam int PR_QUEUE_DEPTH = 4;

  // ------------------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------------------
  localparam int PROBE_REG     = 0;   // RW
  localparam int N_CHAN_REG    = 1;   // RO
  localparam int N_REGIONS_REG = 2;   // RO
  localparam int CTRL_CNFG_REG = 3;   // RO
  localparam int MEM_CNFG_REG  = 4;   // RO
  localparam int PR_CNFG_REG   = 5;   // RO
  localparam int LOWSPEED_REG  = 7;   // RW, board pins
  localparam int PR_CTRL_REG   = 10;  // Self-clearing
  localparam int PR_STAT_REG   = 11;  // RO
  localparam int PR_ADDR_REG   = 12;  // RW
  localparam int PR_LEN_REG    = 13;  // RW, low word

  localparam int PR_START = 0;
  localparam int PR_CTL   = 1;
  localparam int PR_CLR   = 2;
  localparam int PR_DONE  = 0;
  localparam int PR_READY = 1;

  // Build constants
  localparam int         N_CHAN     = 3;
  localparam int         N_REGIONS  = 2;
  localparam logic       AVX_FLOW   = 1'b1;
  localparam logic       BPSS_FLOW  = 1'b0;
  localparam logic       DDR_FLOW   = 1'b1;
  localparam logic [4:0] N_DDR_CHAN = 5'd2;
  localparam logic       PR_FLOW    = 1'b1;

  // ------------------------------------------------------------------------
  // Shared structs
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [AXIL_ADDR_BITS-1:0]   awaddr;
    logic                        awvalid;
    logic [AXIL_DATA_BITS-1:0]   wdata;
    logic [AXIL_DATA_BITS/8-1:0] wstrb;
    logic                        wvalid;
    logic                        bready;
    logic [AXIL_ADDR_BITS-1:0]   araddr;
    logic                        arvalid;
    logic                        rready;
  } axil_req_t;

  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      arready;
    logic [AXIL_DATA_BITS-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
  } axil_rsp_t;

  typedef struct packed {
    logic [ADDR_MSB-1:0]         idx;
    logic [AXIL_DATA_BITS-1:0]   data;
    logic [AXIL_DATA_BITS/8-1:0] strb;
  } reg_wr_t;

  typedef struct packed {
    logic        ctl;
    logic [63:0] paddr;
    logic [31:0] len;
  } dma_req_t;

endpackage
